// ==== hw/mempool_pkg.sv ====
// ============================================================
// Four groups only. The top two address bits name the group
// and the row field limits a bank to 1024 words
// ============================================================
`default_nettype none

package mempool_pkg;

  localparam int unsigned NumGroups = 4;
  localparam int unsigned NumPorts  = 4;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 12;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned GroupBits = 2;
  localparam int unsigned RowWidth  = AddrWidth - GroupBits;

  typedef logic [GroupBits-1:0] group_id_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;

  typedef struct packed {
    group_id_t           group;
    logic [RowWidth-1:0] row;
  } addr_t;

  typedef struct packed {
    logic      wen;
    addr_t     addr;
    data_t     wdata;
    id_t       id;
    group_id_t origin;
  } tcdm_req_t;

  typedef struct packed {
    data_t rdata;
    id_t   id;
  } tcdm_resp_t;

  // Value is the XOR distance between requester and target group
  typedef enum logic [1:0] {
    PortLocal     = 2'd0,
    PortNorth     = 2'd2,
    PortEast      = 2'd1,
    PortNortheast = 2'd3
  } port_e;

  // First valid port at or after start
  function automatic port_e rr_pick(input logic [NumPorts-1:0] valid, input port_e start);
    port_e pick;
    pick = start;
    for (int k = NumPorts - 1; k >= 0; k--) begin
      if (valid[2'(start + k)]) begin
        pick = port_e'(2'(start + k));
      end
    end
    return pick;
  endfunction

endpackage

`default_nettype wire

// ==== hw/tcdm_bank.sv ====
// ============================================================
// Single-ported bank with one access per cycle. BankWords must
// be a power of two no larger than 1024
// ============================================================
`default_nettype none

module tcdm_bank
  import mempool_pkg::*;
#(
  parameter int unsigned BankWords = 256
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  tcdm_req_t  [NumPorts-1:0] req_i,
  input  logic       [NumPorts-1:0] req_valid_i,
  output logic       [NumPorts-1:0] req_ready_o,
  output tcdm_resp_t [NumPorts-1:0] resp_o,
  output logic       [NumPorts-1:0] resp_valid_o,
  input  logic       [NumPorts-1:0] resp_ready_i
);

  localparam int unsigned IdxWidth = $clog2(BankWords);

  data_t               mem_q [BankWords];
  port_e               rr_q;
  port_e               grant;
  tcdm_req_t           req;
  logic [IdxWidth-1:0] idx;
  logic                can_accept;
  logic                accept;
  logic                resp_valid_q;
  port_e               resp_port_q;
  tcdm_resp_t          resp_q;

  // Free when no response is pending or it leaves this cycle
  assign can_accept = !resp_valid_q || resp_ready_i[resp_port_q];
  assign grant      = rr_pick(req_valid_i, rr_q);
  assign req        = req_i[grant];
  assign accept     = can_accept && req_valid_i[grant];
  assign idx        = req.addr.row[IdxWidth-1:0];

  assign req_ready_o = can_accept ? (NumPorts'(1) << grant) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q         <= PortLocal;
      resp_valid_q <= 1'b0;
      resp_port_q  <= PortLocal;
    end else begin
      if (accept) begin
        rr_q        <= port_e'(2'(grant + 1));
        resp_port_q <= grant;
      end
      if (can_accept) begin
        resp_valid_q <= accept;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req.wen) begin
        mem_q[idx] <= req.wdata;
      end
      resp_q.rdata <= mem_q[idx];
      resp_q.id    <= req.id;
    end
  end

  // Payload goes to every port but only the served one sees valid
  assign resp_o       = {NumPorts{resp_q}};
  assign resp_valid_o = resp_valid_q ? (NumPorts'(1) << resp_port_q) : '0;

endmodule

`default_nettype wire

// ==== hw/group_router.sv ====
// ============================================================
// Routes by target group. Responses from different links may
// reach the core out of order and are told apart by id
// ============================================================
`default_nettype none

module group_router
  import mempool_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  group_id_t  group_id_i,
  input  tcdm_req_t  core_req_i,
  input  logic       core_req_valid_i,
  output logic       core_req_ready_o,
  output tcdm_resp_t core_resp_o,
  output logic       core_resp_valid_o,
  input  logic       core_resp_ready_i,
  output tcdm_req_t  local_req_o,
  output logic       local_req_valid_o,
  input  logic       local_req_ready_i,
  input  tcdm_resp_t local_resp_i,
  input  logic       local_resp_valid_i,
  output logic       local_resp_ready_o,
  output tcdm_req_t  tcdm_master_north_req_o,
  output logic       tcdm_master_north_req_valid_o,
  input  logic       tcdm_master_north_req_ready_i,
  input  tcdm_resp_t tcdm_master_north_resp_i,
  input  logic       tcdm_master_north_resp_valid_i,
  output logic       tcdm_master_north_resp_ready_o,
  output tcdm_req_t  tcdm_master_east_req_o,
  output logic       tcdm_master_east_req_valid_o,
  input  logic       tcdm_master_east_req_ready_i,
  input  tcdm_resp_t tcdm_master_east_resp_i,
  input  logic       tcdm_master_east_resp_valid_i,
  output logic       tcdm_master_east_resp_ready_o,
  output tcdm_req_t  tcdm_master_northeast_req_o,
  output logic       tcdm_master_northeast_req_valid_o,
  input  logic       tcdm_master_northeast_req_ready_i,
  input  tcdm_resp_t tcdm_master_northeast_resp_i,
  input  logic       tcdm_master_northeast_resp_valid_i,
  output logic       tcdm_master_northeast_resp_ready_o
);

  tcdm_req_t                    req;
  port_e                        dir;
  logic       [NumPorts-1:0]    dir_valid;
  logic       [NumPorts-1:0]    dir_ready;
  tcdm_resp_t [NumPorts-1:0]    resp;
  logic       [NumPorts-1:0]    resp_valid;
  logic       [NumPorts-1:0]    resp_ready;
  port_e                        rr_q;
  port_e                        sel;
  port_e                        lock_sel_q;
  logic                         lock_q;

  // XOR of target and own group gives the link
  assign dir = port_e'(core_req_i.addr.group ^ group_id_i);

  always_comb begin
    req        = core_req_i;
    req.origin = group_id_i;
  end

  assign local_req_o                 = req;
  assign tcdm_master_north_req_o     = req;
  assign tcdm_master_east_req_o      = req;
  assign tcdm_master_northeast_req_o = req;

  assign dir_valid = core_req_valid_i ? (NumPorts'(1) << dir) : '0;
  assign {tcdm_master_northeast_req_valid_o, tcdm_master_north_req_valid_o,
          tcdm_master_east_req_valid_o, local_req_valid_o} = dir_valid;
  assign dir_ready = {tcdm_master_northeast_req_ready_i, tcdm_master_north_req_ready_i,
                      tcdm_master_east_req_ready_i, local_req_ready_i};
  assign core_req_ready_o = dir_ready[dir];

  // Response sources in port_e order
  assign resp       = {tcdm_master_northeast_resp_i, tcdm_master_north_resp_i,
                       tcdm_master_east_resp_i, local_resp_i};
  assign resp_valid = {tcdm_master_northeast_resp_valid_i, tcdm_master_north_resp_valid_i,
                       tcdm_master_east_resp_valid_i, local_resp_valid_i};
  assign {tcdm_master_northeast_resp_ready_o, tcdm_master_north_resp_ready_o,
          tcdm_master_east_resp_ready_o, local_resp_ready_o} = resp_ready;

  // Choice is frozen while the core stalls a response
  assign sel               = lock_q ? lock_sel_q : rr_pick(resp_valid, rr_q);
  assign core_resp_o       = resp[sel];
  assign core_resp_valid_o = resp_valid[sel];
  assign resp_ready        = core_resp_ready_i ? (NumPorts'(1) << sel) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= PortLocal;
      lock_q     <= 1'b0;
      lock_sel_q <= PortLocal;
    end else if (core_resp_valid_o) begin
      if (core_resp_ready_i) begin
        rr_q   <= port_e'(2'(sel + 1));
        lock_q <= 1'b0;
      end else begin
        lock_q     <= 1'b1;
        lock_sel_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mempool_group.sv ====
// ============================================================
// One group. Bypass traffic costs one extra cycle each way
// ============================================================
`default_nettype none

module mempool_group
  import mempool_pkg::*;
#(
  parameter int unsigned BankWords = 256
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  group_id_t  group_id_i,
  input  tcdm_req_t  core_req_i,
  input  logic       core_req_valid_i,
  output logic       core_req_ready_o,
  output tcdm_resp_t core_resp_o,
  output logic       core_resp_valid_o,
  input  logic       core_resp_ready_i,
  output tcdm_req_t  tcdm_master_north_req_o,
  output logic       tcdm_master_north_req_valid_o,
  input  logic       tcdm_master_north_req_ready_i,
  input  tcdm_resp_t tcdm_master_north_resp_i,
  input  logic       tcdm_master_north_resp_valid_i,
  output logic       tcdm_master_north_resp_ready_o,
  output tcdm_req_t  tcdm_master_east_req_o,
  output logic       tcdm_master_east_req_valid_o,
  input  logic       tcdm_master_east_req_ready_i,
  input  tcdm_resp_t tcdm_master_east_resp_i,
  input  logic       tcdm_master_east_resp_valid_i,
  output logic       tcdm_master_east_resp_ready_o,
  output tcdm_req_t  tcdm_master_northeast_req_o,
  output logic       tcdm_master_northeast_req_valid_o,
  input  logic       tcdm_master_northeast_req_ready_i,
  input  tcdm_resp_t tcdm_master_northeast_resp_i,
  input  logic       tcdm_master_northeast_resp_valid_i,
  output logic       tcdm_master_northeast_resp_ready_o,
  output tcdm_req_t  tcdm_master_bypass_req_o,
  output logic       tcdm_master_bypass_req_valid_o,
  input  logic       tcdm_master_bypass_req_ready_i,
  input  tcdm_resp_t tcdm_master_bypass_resp_i,
  input  logic       tcdm_master_bypass_resp_valid_i,
  output logic       tcdm_master_bypass_resp_ready_o,
  input  tcdm_req_t  tcdm_slave_north_req_i,
  input  logic       tcdm_slave_north_req_valid_i,
  output logic       tcdm_slave_north_req_ready_o,
  output tcdm_resp_t tcdm_slave_north_resp_o,
  output logic       tcdm_slave_north_resp_valid_o,
  input  logic       tcdm_slave_north_resp_ready_i,
  input  tcdm_req_t  tcdm_slave_east_req_i,
  input  logic       tcdm_slave_east_req_valid_i,
  output logic       tcdm_slave_east_req_ready_o,
  output tcdm_resp_t tcdm_slave_east_resp_o,
  output logic       tcdm_slave_east_resp_valid_o,
  input  logic       tcdm_slave_east_resp_ready_i,
  input  tcdm_req_t  tcdm_slave_northeast_req_i,
  input  logic       tcdm_slave_northeast_req_valid_i,
  output logic       tcdm_slave_northeast_req_ready_o,
  output tcdm_resp_t tcdm_slave_northeast_resp_o,
  output logic       tcdm_slave_northeast_resp_valid_o,
  input  logic       tcdm_slave_northeast_resp_ready_i,
  input  tcdm_req_t  tcdm_slave_bypass_req_i,
  input  logic       tcdm_slave_bypass_req_valid_i,
  output logic       tcdm_slave_bypass_req_ready_o,
  output tcdm_resp_t tcdm_slave_bypass_resp_o,
  output logic       tcdm_slave_bypass_resp_valid_o,
  input  logic       tcdm_slave_bypass_resp_ready_i
);

  tcdm_req_t  local_req;
  logic       local_req_valid;
  logic       local_req_ready;
  tcdm_resp_t local_resp;
  logic       local_resp_valid;
  logic       local_resp_ready;
  tcdm_req_t  byp_req_q;
  logic       byp_req_valid_q;
  tcdm_resp_t byp_resp_q;
  logic       byp_resp_valid_q;

  group_router i_router (
    .local_req_o       (local_req),
    .local_req_valid_o (local_req_valid),
    .local_req_ready_i (local_req_ready),
    .local_resp_i      (local_resp),
    .local_resp_valid_i(local_resp_valid),
    .local_resp_ready_o(local_resp_ready),
    .*
  );

  // Bank ports in port_e order {northeast, north, east, local}
  tcdm_bank #(
    .BankWords(BankWords)
  ) i_bank (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       ({tcdm_slave_northeast_req_i, tcdm_slave_north_req_i,
                   tcdm_slave_east_req_i, local_req}),
    .req_valid_i ({tcdm_slave_northeast_req_valid_i, tcdm_slave_north_req_valid_i,
                   tcdm_slave_east_req_valid_i, local_req_valid}),
    .req_ready_o ({tcdm_slave_northeast_req_ready_o, tcdm_slave_north_req_ready_o,
                   tcdm_slave_east_req_ready_o, local_req_ready}),
    .resp_o      ({tcdm_slave_northeast_resp_o, tcdm_slave_north_resp_o,
                   tcdm_slave_east_resp_o, local_resp}),
    .resp_valid_o({tcdm_slave_northeast_resp_valid_o, tcdm_slave_north_resp_valid_o,
                   tcdm_slave_east_resp_valid_o, local_resp_valid}),
    .resp_ready_i({tcdm_slave_northeast_resp_ready_i, tcdm_slave_north_resp_ready_i,
                   tcdm_slave_east_resp_ready_i, local_resp_ready})
  );

  // One-entry forwarding stage per direction
  assign tcdm_slave_bypass_req_ready_o   = !byp_req_valid_q || tcdm_master_bypass_req_ready_i;
  assign tcdm_master_bypass_req_o        = byp_req_q;
  assign tcdm_master_bypass_req_valid_o  = byp_req_valid_q;
  assign tcdm_master_bypass_resp_ready_o = !byp_resp_valid_q || tcdm_slave_bypass_resp_ready_i;
  assign tcdm_slave_bypass_resp_o        = byp_resp_q;
  assign tcdm_slave_bypass_resp_valid_o  = byp_resp_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      byp_req_valid_q  <= 1'b0;
      byp_resp_valid_q <= 1'b0;
    end else begin
      if (tcdm_slave_bypass_req_ready_o) begin
        byp_req_valid_q <= tcdm_slave_bypass_req_valid_i;
      end
      if (tcdm_master_bypass_resp_ready_o) begin
        byp_resp_valid_q <= tcdm_master_bypass_resp_valid_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tcdm_slave_bypass_req_valid_i && tcdm_slave_bypass_req_ready_o) begin
      byp_req_q <= tcdm_slave_bypass_req_i;
    end
    if (tcdm_master_bypass_resp_valid_i && tcdm_master_bypass_resp_ready_o) begin
      byp_resp_q <= tcdm_master_bypass_resp_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mempool_cluster.sv ====
// ============================================================
// Exactly four groups. Northeast goes north first and then
// leaves through the bypass port of that group
// ============================================================
`default_nettype none

module mempool_cluster
  import mempool_pkg::*;
#(
  parameter int unsigned BankWords = 256
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  tcdm_req_t  [NumGroups-1:0] core_req_i,
  input  logic       [NumGroups-1:0] core_req_valid_i,
  output logic       [NumGroups-1:0] core_req_ready_o,
  output tcdm_resp_t [NumGroups-1:0] core_resp_o,
  output logic       [NumGroups-1:0] core_resp_valid_o,
  input  logic       [NumGroups-1:0] core_resp_ready_i
);

  // Links indexed by the group whose master drives the request
  tcdm_req_t  [NumGroups-1:0] north_req;
  tcdm_resp_t [NumGroups-1:0] north_resp;
  logic [NumGroups-1:0] north_req_valid, north_req_ready, north_resp_valid, north_resp_ready;
  tcdm_req_t  [NumGroups-1:0] east_req;
  tcdm_resp_t [NumGroups-1:0] east_resp;
  logic [NumGroups-1:0] east_req_valid, east_req_ready, east_resp_valid, east_resp_ready;
  tcdm_req_t  [NumGroups-1:0] ne_req;
  tcdm_resp_t [NumGroups-1:0] ne_resp;
  logic [NumGroups-1:0] ne_req_valid, ne_req_ready, ne_resp_valid, ne_resp_ready;
  tcdm_req_t  [NumGroups-1:0] byp_req;
  tcdm_resp_t [NumGroups-1:0] byp_resp;
  logic [NumGroups-1:0] byp_req_valid, byp_req_ready, byp_resp_valid, byp_resp_ready;

  if (NumGroups != 4) begin : gen_check
    $fatal(1, "mempool_cluster supports exactly four groups");
  end

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    mempool_group #(
      .BankWords(BankWords)
    ) i_group (
      .clk_i                             (clk_i),
      .reset_i                           (reset_i),
      .group_id_i                        (group_id_t'(g)),
      .core_req_i                        (core_req_i[g]),
      .core_req_valid_i                  (core_req_valid_i[g]),
      .core_req_ready_o                  (core_req_ready_o[g]),
      .core_resp_o                       (core_resp_o[g]),
      .core_resp_valid_o                 (core_resp_valid_o[g]),
      .core_resp_ready_i                 (core_resp_ready_i[g]),
      .tcdm_master_north_req_o           (north_req[g]),
      .tcdm_master_north_req_valid_o     (north_req_valid[g]),
      .tcdm_master_north_req_ready_i     (north_req_ready[g]),
      .tcdm_master_north_resp_i          (north_resp[g]),
      .tcdm_master_north_resp_valid_i    (north_resp_valid[g]),
      .tcdm_master_north_resp_ready_o    (north_resp_ready[g]),
      .tcdm_master_east_req_o            (east_req[g]),
      .tcdm_master_east_req_valid_o      (east_req_valid[g]),
      .tcdm_master_east_req_ready_i      (east_req_ready[g]),
      .tcdm_master_east_resp_i           (east_resp[g]),
      .tcdm_master_east_resp_valid_i     (east_resp_valid[g]),
      .tcdm_master_east_resp_ready_o     (east_resp_ready[g]),
      .tcdm_master_northeast_req_o       (ne_req[g]),
      .tcdm_master_northeast_req_valid_o (ne_req_valid[g]),
      .tcdm_master_northeast_req_ready_i (ne_req_ready[g]),
      .tcdm_master_northeast_resp_i      (ne_resp[g]),
      .tcdm_master_northeast_resp_valid_i(ne_resp_valid[g]),
      .tcdm_master_northeast_resp_ready_o(ne_resp_ready[g]),
      .tcdm_master_bypass_req_o          (byp_req[g]),
      .tcdm_master_bypass_req_valid_o    (byp_req_valid[g]),
      .tcdm_master_bypass_req_ready_i    (byp_req_ready[g]),
      .tcdm_master_bypass_resp_i         (byp_resp[g]),
      .tcdm_master_bypass_resp_valid_i   (byp_resp_valid[g]),
      .tcdm_master_bypass_resp_ready_o   (byp_resp_ready[g]),
      .tcdm_slave_north_req_i            (north_req[g ^ 2]),
      .tcdm_slave_north_req_valid_i      (north_req_valid[g ^ 2]),
      .tcdm_slave_north_req_ready_o      (north_req_ready[g ^ 2]),
      .tcdm_slave_north_resp_o           (north_resp[g ^ 2]),
      .tcdm_slave_north_resp_valid_o     (north_resp_valid[g ^ 2]),
      .tcdm_slave_north_resp_ready_i     (north_resp_ready[g ^ 2]),
      .tcdm_slave_east_req_i             (east_req[g ^ 1]),
      .tcdm_slave_east_req_valid_i       (east_req_valid[g ^ 1]),
      .tcdm_slave_east_req_ready_o       (east_req_ready[g ^ 1]),
      .tcdm_slave_east_resp_o            (east_resp[g ^ 1]),
      .tcdm_slave_east_resp_valid_o      (east_resp_valid[g ^ 1]),
      .tcdm_slave_east_resp_ready_i      (east_resp_ready[g ^ 1]),
      // Second hop comes from the bypass master of the east neighbour
      .tcdm_slave_northeast_req_i        (byp_req[g ^ 1]),
      .tcdm_slave_northeast_req_valid_i  (byp_req_valid[g ^ 1]),
      .tcdm_slave_northeast_req_ready_o  (byp_req_ready[g ^ 1]),
      .tcdm_slave_northeast_resp_o       (byp_resp[g ^ 1]),
      .tcdm_slave_northeast_resp_valid_o (byp_resp_valid[g ^ 1]),
      .tcdm_slave_northeast_resp_ready_i (byp_resp_ready[g ^ 1]),
      // First hop from the northeast master of the north neighbour
      .tcdm_slave_bypass_req_i           (ne_req[g ^ 2]),
      .tcdm_slave_bypass_req_valid_i     (ne_req_valid[g ^ 2]),
      .tcdm_slave_bypass_req_ready_o     (ne_req_ready[g ^ 2]),
      .tcdm_slave_bypass_resp_o          (ne_resp[g ^ 2]),
      .tcdm_slave_bypass_resp_valid_o    (ne_resp_valid[g ^ 2]),
      .tcdm_slave_bypass_resp_ready_i    (ne_resp_ready[g ^ 2])
    );
  end : gen_groups

endmodule

`default_nettype wire

// ==== test/tb_mempool_cluster.sv ====
// ============================================================
// Runs from the project root and reads test/cluster_patterns.hex.
// A phase ends where the port number drops. Ports run in parallel
// within a phase and each phase drains before the next one
// ============================================================
`default_nettype none

module tb_mempool_cluster
  import mempool_pkg::*;
();

  localparam int unsigned BankWords     = 256;
  localparam int unsigned MaxLines      = 64;
  localparam int unsigned Cols          = 6;
  localparam int unsigned ResetCycles   = 10;
  localparam int unsigned CyclesPerLine = 40;
  localparam int unsigned NumIds        = 1 << IdWidth;

  logic                       clk;
  logic                       reset;
  tcdm_req_t  [NumGroups-1:0] core_req;
  logic       [NumGroups-1:0] core_req_valid;
  logic       [NumGroups-1:0] core_req_ready;
  tcdm_resp_t [NumGroups-1:0] core_resp;
  logic       [NumGroups-1:0] core_resp_valid;
  logic       [NumGroups-1:0] core_resp_ready;

  logic [31:0] pat_mem [MaxLines*Cols];

  // Outstanding requests per port and id
  logic        pend_q      [NumGroups][NumIds];
  logic        pend_rd     [NumGroups][NumIds];
  logic [31:0] pend_data   [NumGroups][NumIds];
  int          pend_line   [NumGroups][NumIds];
  int          outstanding [NumGroups];

  integer seed = 70;
  int     num_lines;
  int     errors;
  int     checks;
  int     responses;
  int     cycle_cnt;
  int     timeout_cycles;
  logic   started;

  mempool_cluster #(
    .BankWords(BankWords)
  ) u_mempool_cluster (
    .clk_i            (clk),
    .reset_i          (reset),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_resp_o      (core_resp),
    .core_resp_valid_o(core_resp_valid),
    .core_resp_ready_i(core_resp_ready)
  );

  always #5 clk = ~clk;

  function automatic int line_port(input int l);
    return int'(pat_mem[l*Cols]);
  endfunction

  function automatic int line_group(input int l);
    return int'(pat_mem[l*Cols+2][AddrWidth-1:AddrWidth-2]);
  endfunction

  function automatic string test_name(input int l);
    string path;
    case (line_port(l) ^ line_group(l))
      0:       path = "local";
      1:       path = "east";
      2:       path = "north";
      default: path = "northeast";
    endcase
    return $sformatf("%s %s line %0d", path, pat_mem[l*Cols+1][0] ? "write" : "read", l + 1);
  endfunction

  function automatic int total_outstanding();
    int sum;
    sum = 0;
    for (int p = 0; p < NumGroups; p++) begin
      sum += outstanding[p];
    end
    return sum;
  endfunction

  // Called one unit after a rising edge and returns at the same point
  task automatic send_request(input int p, input int l);
    tcdm_req_t req;
    logic      accepted;
    req       = '0;
    req.wen   = pat_mem[l*Cols+1][0];
    req.addr  = addr_t'(pat_mem[l*Cols+2][AddrWidth-1:0]);
    req.wdata = pat_mem[l*Cols+3];
    req.id    = id_t'(pat_mem[l*Cols+4]);
    assert (!pend_q[p][req.id]) else begin
      errors++;
      $display("Pattern line %0d reuses id %0d while it is outstanding", l + 1, req.id);
    end
    core_req[p]       = req;
    core_req_valid[p] = 1'b1;
    started           = 1'b1;
    accepted          = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = core_req_ready[p];
      if (accepted) begin
        pend_q[p][req.id]    = 1'b1;
        pend_rd[p][req.id]   = !req.wen;
        pend_data[p][req.id] = pat_mem[l*Cols+5];
        pend_line[p][req.id] = l;
        outstanding[p]++;
      end
      @(posedge clk);
      #1;
    end
    core_req_valid[p] = 1'b0;
  endtask

  task automatic run_port(input int p, input int first, input int last);
    for (int l = first; l < last; l++) begin
      if (line_port(l) == p) begin
        send_request(p, l);
      end
    end
  endtask

  task automatic check_response(input int p, input tcdm_resp_t resp);
    int    l;
    string name;
    responses++;
    assert (pend_q[p][resp.id] === 1'b1) else begin
      errors++;
      $display("Port %0d returned id %0d with no such request outstanding", p, resp.id);
    end
    if (pend_q[p][resp.id] === 1'b1) begin
      l    = pend_line[p][resp.id];
      name = test_name(l);
      // Write responses carry only the id
      if (pend_rd[p][resp.id]) begin
        checks++;
        assert (resp.rdata === pend_data[p][resp.id]) else begin
          errors++;
          $display("[FAIL] %s: expected %h, actual %h", name, pend_data[p][resp.id],
                   resp.rdata);
        end
      end
      pend_q[p][resp.id] = 1'b0;
      outstanding[p]--;
    end
  endtask

  // Random back-pressure on every core response port
  always @(posedge clk) begin
    #1;
    for (int p = 0; p < NumGroups; p++) begin
      core_resp_ready[p] = ($random(seed) & 3) != 0;
    end
  end

  always @(negedge clk) begin
    if (!reset && !started) begin
      assert (core_resp_valid === '0) else begin
        errors++;
        $display("Core response valid raised before any request was sent");
      end
    end
    if (!reset) begin
      for (int p = 0; p < NumGroups; p++) begin
        if (core_resp_valid[p] && core_resp_ready[p]) begin
          check_response(p, core_resp[p]);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
      $display("Timeout after %0d cycles, %0d requests never got a response",
               cycle_cnt, total_outstanding());
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int first;
    int last;
    clk             = 1'b0;
    reset           = 1'b1;
    core_req        = '0;
    core_req_valid  = '0;
    core_resp_ready = '0;
    started         = 1'b0;
    errors          = 0;
    checks          = 0;
    responses       = 0;
    cycle_cnt       = 0;
    timeout_cycles  = 0;
    for (int p = 0; p < NumGroups; p++) begin
      outstanding[p] = 0;
      for (int i = 0; i < NumIds; i++) begin
        pend_q[p][i] = 1'b0;
      end
    end
    for (int i = 0; i < MaxLines * Cols; i++) begin
      pat_mem[i] = '1;
    end
    $readmemh("test/cluster_patterns.hex", pat_mem);
    num_lines = 0;
    while (num_lines < MaxLines && pat_mem[num_lines*Cols] != 32'hFFFF_FFFF) begin
      num_lines++;
    end
    assert (num_lines > 0) else begin
      errors++;
      $display("No pattern lines could be read from the data file");
    end
    timeout_cycles = CyclesPerLine * num_lines + ResetCycles;

    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    // Idle cycles so the monitor sees response valid stay low
    repeat (3) @(posedge clk);

    first = 0;
    while (first < num_lines) begin
      last = first + 1;
      while (last < num_lines && line_port(last) >= line_port(last - 1)) begin
        last++;
      end
      @(posedge clk);
      #1;
      fork
        run_port(0, first, last);
        run_port(1, first, last);
        run_port(2, first, last);
        run_port(3, first, last);
      join
      while (total_outstanding() != 0) begin
        @(posedge clk);
      end
      first = last;
    end

    // Room for any duplicated response to show up
    repeat (5) @(posedge clk);
    $display("Lines %0d, responses %0d, data checks %0d, errors %0d",
             num_lines, responses, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mini_mempool.f ====
hw/mempool_pkg.sv
hw/tcdm_bank.sv
hw/group_router.sv
hw/mempool_group.sv
hw/mempool_cluster.sv
test/tb_mempool_cluster.sv

// ==== test/cluster_patterns.hex ====
// port wen addr wdata id rdata, rdata is not checked on writes
// A drop in port number starts a new phase
0 1 000 D000BEEF 0 00000000
0 1 401 D010BEEF 1 00000000
0 1 802 D020BEEF 2 00000000
0 1 C03 D030BEEF 3 00000000
0 0 000 00000000 4 D000BEEF
0 0 401 00000000 5 D010BEEF
0 0 802 00000000 6 D020BEEF
0 0 C03 00000000 7 D030BEEF
1 1 410 D100BEEF 0 00000000
1 1 011 D110BEEF 1 00000000
1 1 C12 D120BEEF 2 00000000
1 1 813 D130BEEF 3 00000000
1 0 410 00000000 4 D100BEEF
1 0 011 00000000 5 D110BEEF
1 0 C12 00000000 6 D120BEEF
1 0 813 00000000 7 D130BEEF
2 1 820 D200BEEF 0 00000000
2 1 C21 D210BEEF 1 00000000
2 1 022 D220BEEF 2 00000000
2 1 423 D230BEEF 3 00000000
2 0 820 00000000 4 D200BEEF
2 0 C21 00000000 5 D210BEEF
2 0 022 00000000 6 D220BEEF
2 0 423 00000000 7 D230BEEF
3 1 C30 D300BEEF 0 00000000
3 1 831 D310BEEF 1 00000000
3 1 432 D320BEEF 2 00000000
3 1 033 D330BEEF 3 00000000
3 0 C30 00000000 4 D300BEEF
3 0 831 00000000 5 D310BEEF
3 0 432 00000000 6 D320BEEF
3 0 033 00000000 7 D330BEEF
0 0 033 00000000 8 D330BEEF
0 0 000 00000000 9 D000BEEF
1 0 423 00000000 8 D230BEEF
1 0 000 00000000 9 D000BEEF
2 0 813 00000000 8 D130BEEF
2 0 000 00000000 9 D000BEEF
3 0 C03 00000000 8 D030BEEF
3 0 000 00000000 9 D000BEEF
